// ==== hw/cp0_pkg.sv ====
package cp0_pkg;

    typedef logic [7:0] cp0_addr_t;  // {reg[4:0], sel[2:0]}

    localparam cp0_addr_t ADDR_INDEX    = {5'd0, 3'd0};
    localparam cp0_addr_t ADDR_ENTRYLO0 = {5'd2, 3'd0};
    localparam cp0_addr_t ADDR_ENTRYLO1 = {5'd3, 3'd0};
    localparam cp0_addr_t ADDR_CONTEXT  = {5'd4, 3'd0};
    localparam cp0_addr_t ADDR_BADVADDR = {5'd8, 3'd0};
    localparam cp0_addr_t ADDR_COUNT    = {5'd9, 3'd0};
    localparam cp0_addr_t ADDR_ENTRYHI  = {5'd10, 3'd0};
    localparam cp0_addr_t ADDR_COMPARE  = {5'd11, 3'd0};
    localparam cp0_addr_t ADDR_STATUS   = {5'd12, 3'd0};
    localparam cp0_addr_t ADDR_CAUSE    = {5'd13, 3'd0};
    localparam cp0_addr_t ADDR_EPC      = {5'd14, 3'd0};
    localparam cp0_addr_t ADDR_PRID     = {5'd15, 3'd0};
    localparam cp0_addr_t ADDR_EBASE    = {5'd15, 3'd1};
    localparam cp0_addr_t ADDR_CONFIG   = {5'd16, 3'd0};
    localparam cp0_addr_t ADDR_CONFIG1  = {5'd16, 3'd1};

    localparam logic [31:0] STATUS_RESET  = 32'h1040_0004;  // CU0, BEV, ERL
    localparam logic [31:0] EBASE_RESET   = 32'h8000_0000;
    localparam logic [31:0] PRID_VALUE    = 32'h0001_8000;
    localparam logic [31:0] CONFIG_FIXED  = 32'h8000_0080;  // M set, release 1
    localparam logic [31:0] CONFIG1_VALUE = 32'h1E18_0C00;

    // Software writable fields
    localparam logic [31:0] STATUS_WMASK  = 32'h1040_FF17;
    localparam logic [31:0] CAUSE_WMASK   = 32'h0080_0300;
    localparam logic [31:0] EBASE_WMASK   = 32'h3FFF_F000;
    localparam logic [31:0] ENTRYHI_WMASK = 32'hFFFF_E0FF;
    localparam logic [31:0] ENTRYLO_WMASK = 32'h3FFF_FFFF;
    localparam logic [31:0] INDEX_WMASK   = 32'h0000_000F;
    localparam logic [31:0] CONTEXT_WMASK = 32'hFF80_0000;
    localparam logic [31:0] CONFIG_WMASK  = 32'h0000_0007;

    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;

    localparam logic [4:0] EXC_INT  = 5'd0;
    localparam logic [4:0] EXC_MOD  = 5'd1;
    localparam logic [4:0] EXC_TLBL = 5'd2;
    localparam logic [4:0] EXC_TLBS = 5'd3;

    localparam logic [31:0] VEC_BOOT_BASE = 32'hBFC0_0200;
    localparam logic [31:0] OFF_REFILL    = 32'h0000_0000;
    localparam logic [31:0] OFF_GENERAL   = 32'h0000_0180;
    localparam logic [31:0] OFF_IRQ       = 32'h0000_0200;

    typedef enum logic [2:0] {
        OP_MFC0,
        OP_MTC0,
        OP_TLBWI,
        OP_TLBP,
        OP_ERET
    } cp0_op_e;

    typedef struct packed {
        cp0_op_e     op;
        cp0_addr_t   addr;
        logic [31:0] wdata;
    } cp0_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } cp0_rsp_t;

    typedef struct packed {
        logic [4:0]  code;
        logic        bd;
        logic        refill;
        logic [31:0] epc;
        logic [31:0] bad_vaddr;
        logic        badv_we;
        logic [7:0]  asid;
        logic        asid_we;
    } exc_req_t;

    typedef struct packed {
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [23:0] pfn0;
        logic [23:0] pfn1;
        logic [2:0]  c0;
        logic [2:0]  c1;
        logic        d0;
        logic        v0;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        logic        user_mode;
        logic        exl;
        logic        allow_int;
        logic        bev;
        logic        iv;
        logic [7:0]  im;
        logic [1:0]  sw_int;
        logic [19:0] ebase;
        logic [7:0]  asid;
    } cp0_status_t;

endpackage

// ==== hw/cp0_regs.sv ====
module cp0_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_en_i,
    input  cp0_pkg::cp0_addr_t           wr_addr_i,
    input  logic [31:0]                  wr_data_i,
    input  logic                         exc_en_i,
    input  cp0_pkg::exc_req_t            exc_i,
    input  logic                         clean_exl_i,
    input  logic                         probe_we_i,
    input  logic [31:0]                  probe_result_i,
    input  logic [5:0]                   hw_int_i,
    input  cp0_pkg::cp0_addr_t           rd_addr_i,
    output logic [31:0]                  rd_data_o,
    input  cp0_pkg::cp0_addr_t           dbg_addr_i,
    output logic [31:0]                  dbg_data_o,
    output cp0_pkg::cp0_status_t         status_o,
    output cp0_pkg::tlb_entry_t          cur_entry_o,
    output logic [cp0_pkg::TLB_IDX_W-1:0] index_o,
    output logic [31:0]                  epc_o,
    output logic                         timer_int_o
);
    import cp0_pkg::*;

    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] count_q;
    logic [31:0] compare_q;
    logic [31:0] context_q;
    logic [31:0] ebase_q;
    logic [31:0] entryhi_q;
    logic [31:0] entrylo0_q;
    logic [31:0] entrylo1_q;
    logic [31:0] index_q;
    logic [31:0] config_q;
    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;
    logic        timer_q;

    function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] mask);
        return (old & ~mask) | (wr_data_i & mask);
    endfunction

    function automatic logic [31:0] read_reg(cp0_addr_t addr);
        logic [31:0] data;
        case (addr)
            ADDR_INDEX:    data = index_q;
            ADDR_ENTRYLO0: data = entrylo0_q;
            ADDR_ENTRYLO1: data = entrylo1_q;
            ADDR_CONTEXT:  data = context_q;
            ADDR_BADVADDR: data = badvaddr_q;
            ADDR_COUNT:    data = count_q;
            ADDR_ENTRYHI:  data = entryhi_q;
            ADDR_COMPARE:  data = compare_q;
            ADDR_STATUS:   data = status_q;
            ADDR_CAUSE:    data = cause_q | {16'b0, hw_int_i, 10'b0};  // Live IP7..IP2
            ADDR_EPC:      data = epc_q;
            ADDR_PRID:     data = PRID_VALUE;
            ADDR_EBASE:    data = ebase_q;
            ADDR_CONFIG:   data = CONFIG_FIXED | config_q;
            ADDR_CONFIG1:  data = CONFIG1_VALUE;
            default:       data = '0;
        endcase
        return data;
    endfunction

    always_comb begin
        rd_data_o = read_reg(rd_addr_i);
    end

    always_comb begin
        dbg_data_o = read_reg(dbg_addr_i);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q   <= STATUS_RESET;
            cause_q    <= '0;
            count_q    <= '0;
            compare_q  <= '0;
            context_q  <= '0;
            ebase_q    <= EBASE_RESET;
            entryhi_q  <= '0;
            entrylo0_q <= '0;
            entrylo1_q <= '0;
            index_q    <= '0;
            config_q   <= '0;
            timer_q    <= 1'b0;
        end else begin
            count_q <= count_q + 32'd1;
            if (compare_q != '0 && compare_q == count_q)
                timer_q <= 1'b1;
            if (wr_en_i) begin
                case (wr_addr_i)
                    ADDR_INDEX:    index_q    <= merge(index_q, INDEX_WMASK);
                    ADDR_ENTRYLO0: entrylo0_q <= merge(entrylo0_q, ENTRYLO_WMASK);
                    ADDR_ENTRYLO1: entrylo1_q <= merge(entrylo1_q, ENTRYLO_WMASK);
                    ADDR_CONTEXT:  context_q  <= merge(context_q, CONTEXT_WMASK);
                    ADDR_COUNT:    count_q    <= wr_data_i;
                    ADDR_ENTRYHI:  entryhi_q  <= merge(entryhi_q, ENTRYHI_WMASK);
                    ADDR_COMPARE: begin
                        compare_q <= wr_data_i;
                        timer_q   <= 1'b0;  // Acknowledge timer
                    end
                    ADDR_STATUS:   status_q   <= merge(status_q, STATUS_WMASK);
                    ADDR_CAUSE:    cause_q    <= merge(cause_q, CAUSE_WMASK);
                    ADDR_EBASE:    ebase_q    <= merge(ebase_q, EBASE_WMASK);
                    ADDR_CONFIG:   config_q   <= merge(config_q, CONFIG_WMASK);
                    default: ;
                endcase
            end
            if (probe_we_i)
                index_q <= probe_result_i;
            if (exc_en_i) begin
                status_q[1]         <= 1'b1;  // EXL
                cause_q[31]         <= exc_i.bd;
                cause_q[6:2]        <= exc_i.code;
                context_q[22:4]     <= exc_i.bad_vaddr[31:13];
                entryhi_q[31:13]    <= exc_i.bad_vaddr[31:13];
                if (exc_i.asid_we)
                    entryhi_q[7:0] <= exc_i.asid;
            end
            if (clean_exl_i)
                status_q[1] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i && wr_addr_i == ADDR_EPC)
            epc_q <= wr_data_i;
        if (exc_en_i) begin
            epc_q <= exc_i.epc;
            if (exc_i.badv_we)
                badvaddr_q <= exc_i.bad_vaddr;
        end
    end

    always_comb begin
        status_o.user_mode = status_q[4:1] == 4'b1000;
        status_o.exl       = status_q[1];
        status_o.allow_int = status_q[2:0] == 3'b001;  // IE set, EXL and ERL clear
        status_o.bev       = status_q[22];
        status_o.iv        = cause_q[23];
        status_o.im        = status_q[15:8];
        status_o.sw_int    = cause_q[9:8];
        status_o.ebase     = ebase_q[31:12];
        status_o.asid      = entryhi_q[7:0];
    end

    always_comb begin
        cur_entry_o.vpn2 = entryhi_q[31:13];
        cur_entry_o.asid = entryhi_q[7:0];
        cur_entry_o.g    = entrylo0_q[0] & entrylo1_q[0];
        cur_entry_o.pfn0 = entrylo0_q[29:6];
        cur_entry_o.pfn1 = entrylo1_q[29:6];
        cur_entry_o.c0   = entrylo0_q[5:3];
        cur_entry_o.c1   = entrylo1_q[5:3];
        cur_entry_o.d0   = entrylo0_q[2];
        cur_entry_o.v0   = entrylo0_q[1];
        cur_entry_o.d1   = entrylo1_q[2];
        cur_entry_o.v1   = entrylo1_q[1];
    end

    assign index_o     = index_q[TLB_IDX_W-1:0];
    assign epc_o       = epc_q;
    assign timer_int_o = timer_q;

endmodule

// ==== hw/cp0_irq.sv ====
module cp0_irq (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [5:0]           hw_int_i,
    input  logic                 timer_int_i,
    input  cp0_pkg::cp0_status_t status_i,
    output logic                 irq_o
);
    import cp0_pkg::*;

    logic [7:0] pending;
    logic [7:0] masked;
    logic       irq_q;

    // Timer shares IP7 with hardware line 5
    assign pending = {hw_int_i[5] | timer_int_i, hw_int_i[4:0], status_i.sw_int};
    assign masked  = pending & status_i.im;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= (|masked) && status_i.allow_int;
        end
    end

    assign irq_o = irq_q;

endmodule

// ==== hw/cp0_tlb.sv ====
module cp0_tlb (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          write_i,
    input  logic [cp0_pkg::TLB_IDX_W-1:0] index_i,
    input  cp0_pkg::tlb_entry_t           entry_i,
    output logic [31:0]                   probe_result_o
);
    import cp0_pkg::*;

    tlb_entry_t             tlb_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] valid_q;
    logic [TLB_ENTRIES-1:0] hit;

    always_ff @(posedge clk) begin
        if (write_i)
            tlb_q[index_i] <= entry_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (write_i) begin
            valid_q[index_i] <= entry_i.v0 | entry_i.v1;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit[i] = valid_q[i] && tlb_q[i].vpn2 == entry_i.vpn2
                     && (tlb_q[i].g || tlb_q[i].asid == entry_i.asid);
        end
    end

    // Walk downwards so the lowest hit wins
    always_comb begin
        probe_result_o = 32'h8000_0000;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i])
                probe_result_o = {{(32 - TLB_IDX_W){1'b0}}, TLB_IDX_W'(i)};
        end
    end

endmodule

// ==== hw/cp0_ctrl.sv ====
module cp0_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cp0_pkg::cp0_req_t    req_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    output cp0_pkg::cp0_rsp_t    rsp_o,
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,
    input  cp0_pkg::exc_req_t    exc_i,
    input  logic                 exc_valid_i,
    output cp0_pkg::redirect_t   redirect_o,
    output logic                 redirect_valid_o,
    input  cp0_pkg::cp0_status_t status_i,
    input  logic [31:0]          epc_i,
    input  logic [31:0]          rd_data_i,
    output cp0_pkg::cp0_addr_t   rd_addr_o,
    output logic                 wr_en_o,
    output logic                 exc_en_o,
    output logic                 clean_exl_o,
    output logic                 probe_we_o,
    output logic                 tlb_write_o
);
    import cp0_pkg::*;

    logic        run_q;
    logic        accept;
    logic        rsp_valid_q;
    cp0_rsp_t    rsp_q;
    logic [31:0] rsp_data;
    logic        redirect_valid_q;
    redirect_t   redirect_q;
    logic [31:0] vec_base;
    logic [31:0] vec_off;

    // Exception always wins over a CPU operation
    assign req_ready_o = run_q && !exc_valid_i && (!rsp_valid_q || rsp_ready_i);
    assign accept      = req_valid_i && req_ready_o;

    assign rd_addr_o   = req_i.addr;
    assign wr_en_o     = accept && req_i.op == OP_MTC0;
    assign tlb_write_o = accept && req_i.op == OP_TLBWI;
    assign probe_we_o  = accept && req_i.op == OP_TLBP;
    assign clean_exl_o = accept && req_i.op == OP_ERET;
    assign exc_en_o    = exc_valid_i;

    always_comb begin
        case (req_i.op)
            OP_MFC0: rsp_data = rd_data_i;
            OP_ERET: rsp_data = epc_i;
            default: rsp_data = '0;
        endcase
    end

    always_comb begin
        vec_base = status_i.bev ? VEC_BOOT_BASE : {status_i.ebase, 12'b0};
        if (exc_i.refill && !status_i.exl)
            vec_off = OFF_REFILL;
        else if (exc_i.code == EXC_INT && status_i.iv)
            vec_off = OFF_IRQ;
        else
            vec_off = OFF_GENERAL;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q            <= 1'b0;
            rsp_valid_q      <= 1'b0;
            redirect_valid_q <= 1'b0;
        end else begin
            run_q            <= 1'b1;
            redirect_valid_q <= exc_valid_i || clean_exl_o;
            if (accept)
                rsp_valid_q <= 1'b1;
            else if (rsp_ready_i)
                rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            rsp_q.rdata <= rsp_data;
        if (exc_valid_i)
            redirect_q.target <= vec_base + vec_off;
        else if (clean_exl_o)
            redirect_q.target <= epc_i;  // ERET
    end

    assign rsp_o            = rsp_q;
    assign rsp_valid_o      = rsp_valid_q;
    assign redirect_o       = redirect_q;
    assign redirect_valid_o = redirect_valid_q;

endmodule

// ==== hw/cp0_top.sv ====
module cp0_top (
    input  logic               clk,
    input  logic               rst_n,
    input  cp0_pkg::cp0_req_t  req_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    output cp0_pkg::cp0_rsp_t  rsp_o,
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    input  cp0_pkg::exc_req_t  exc_i,
    input  logic               exc_valid_i,
    output cp0_pkg::redirect_t redirect_o,
    output logic               redirect_valid_o,
    input  logic [5:0]         hw_int_i,
    output logic               irq_o,
    output logic               user_mode_o,
    output logic [7:0]         asid_o,
    input  cp0_pkg::cp0_addr_t dbg_addr_i,
    output logic [31:0]        dbg_data_o
);
    import cp0_pkg::*;

    cp0_status_t          status;
    tlb_entry_t           cur_entry;
    logic [TLB_IDX_W-1:0] index;
    logic [31:0]          epc;
    logic [31:0]          rd_data;
    cp0_addr_t            rd_addr;
    logic [31:0]          probe_result;
    logic                 timer_int;
    logic                 wr_en;
    logic                 exc_en;
    logic                 clean_exl;
    logic                 probe_we;
    logic                 tlb_write;

    cp0_ctrl i_cp0_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_i            (req_i),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .rsp_o            (rsp_o),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_ready_i      (rsp_ready_i),
        .exc_i            (exc_i),
        .exc_valid_i      (exc_valid_i),
        .redirect_o       (redirect_o),
        .redirect_valid_o (redirect_valid_o),
        .status_i         (status),
        .epc_i            (epc),
        .rd_data_i        (rd_data),
        .rd_addr_o        (rd_addr),
        .wr_en_o          (wr_en),
        .exc_en_o         (exc_en),
        .clean_exl_o      (clean_exl),
        .probe_we_o       (probe_we),
        .tlb_write_o      (tlb_write)
    );

    cp0_regs i_cp0_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_en_i        (wr_en),
        .wr_addr_i      (req_i.addr),
        .wr_data_i      (req_i.wdata),
        .exc_en_i       (exc_en),
        .exc_i          (exc_i),
        .clean_exl_i    (clean_exl),
        .probe_we_i     (probe_we),
        .probe_result_i (probe_result),
        .hw_int_i       (hw_int_i),
        .rd_addr_i      (rd_addr),
        .rd_data_o      (rd_data),
        .dbg_addr_i     (dbg_addr_i),
        .dbg_data_o     (dbg_data_o),
        .status_o       (status),
        .cur_entry_o    (cur_entry),
        .index_o        (index),
        .epc_o          (epc),
        .timer_int_o    (timer_int)
    );

    cp0_tlb i_cp0_tlb (
        .clk            (clk),
        .rst_n          (rst_n),
        .write_i        (tlb_write),
        .index_i        (index),
        .entry_i        (cur_entry),
        .probe_result_o (probe_result)
    );

    cp0_irq i_cp0_irq (
        .clk         (clk),
        .rst_n       (rst_n),
        .hw_int_i    (hw_int_i),
        .timer_int_i (timer_int),
        .status_i    (status),
        .irq_o       (irq_o)
    );

    assign user_mode_o = status.user_mode;
    assign asid_o      = status.asid;

endmodule

// ==== sim/cp0_tb.sv ====
module cp0_tb;
    timeunit 1ns;
    timeprecision 10ps;
    import cp0_pkg::*;

    localparam int TIMEOUT = 200;

    logic        clk;
    logic        rst_n;
    cp0_req_t    req_i;
    logic        req_valid_i;
    logic        req_ready_o;
    cp0_rsp_t    rsp_o;
    logic        rsp_valid_o;
    logic        rsp_ready_i;
    exc_req_t    exc_i;
    logic        exc_valid_i;
    redirect_t   redirect_o;
    logic        redirect_valid_o;
    logic [5:0]  hw_int_i;
    logic        irq_o;
    logic        user_mode_o;
    logic [7:0]  asid_o;
    cp0_addr_t   dbg_addr_i;
    logic [31:0] dbg_data_o;

    integer seed = 32'h2cf7_740f;

    // Reference register state
    logic [31:0] m_status;
    logic [31:0] m_cause;
    logic [31:0] m_context;
    logic [31:0] m_ebase;
    logic [31:0] m_entryhi;
    logic [31:0] m_lo0;
    logic [31:0] m_lo1;
    logic [31:0] m_index;
    logic [31:0] m_config;
    logic [31:0] m_epc;
    logic [31:0] m_badv;

    // Reference TLB
    logic [18:0] t_vpn2 [TLB_ENTRIES];
    logic [7:0]  t_asid [TLB_ENTRIES];
    logic        t_g    [TLB_ENTRIES];
    logic        t_v    [TLB_ENTRIES];

    cp0_addr_t reg_list [13] = '{ADDR_INDEX, ADDR_ENTRYLO0, ADDR_ENTRYLO1, ADDR_CONTEXT,
                                 ADDR_BADVADDR, ADDR_ENTRYHI, ADDR_STATUS, ADDR_CAUSE,
                                 ADDR_EPC, ADDR_PRID, ADDR_EBASE, ADDR_CONFIG, ADDR_CONFIG1};
    cp0_addr_t exc_list [6] = '{ADDR_EPC, ADDR_CAUSE, ADDR_BADVADDR, ADDR_ENTRYHI,
                                ADDR_STATUS, ADDR_CONTEXT};

    cp0_top i_cp0_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_rsp(string name, cp0_rsp_t got, cp0_rsp_t exp);
        if (got !== exp)
            fail_run($sformatf("ERROR %s: got %h, expected %h", name, got.rdata, exp.rdata));
    endtask

    task automatic check_redirect(redirect_t got, redirect_t exp);
        if (got !== exp)
            fail_run($sformatf("ERROR redirect_o: got %h, expected %h", got.target, exp.target));
    endtask

    task automatic check_bit(string name, logic [7:0] got, logic [7:0] exp);
        if (got !== exp)
            fail_run($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] masked(logic [31:0] old, logic [31:0] data,
                                           logic [31:0] mask);
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic logic [31:0] expected_read(cp0_addr_t addr);
        case (addr)
            ADDR_INDEX:    return m_index;
            ADDR_ENTRYLO0: return m_lo0;
            ADDR_ENTRYLO1: return m_lo1;
            ADDR_CONTEXT:  return m_context;
            ADDR_BADVADDR: return m_badv;
            ADDR_ENTRYHI:  return m_entryhi;
            ADDR_STATUS:   return m_status;
            ADDR_CAUSE:    return m_cause | {16'b0, hw_int_i, 10'b0};  // Live IP bits
            ADDR_EPC:      return m_epc;
            ADDR_PRID:     return PRID_VALUE;
            ADDR_EBASE:    return m_ebase;
            ADDR_CONFIG:   return CONFIG_FIXED | m_config;
            ADDR_CONFIG1:  return CONFIG1_VALUE;
            default:       return '0;
        endcase
    endfunction

    task automatic apply_mtc0(cp0_addr_t addr, logic [31:0] data);
        case (addr)
            ADDR_INDEX:    m_index   = masked(m_index, data, INDEX_WMASK);
            ADDR_ENTRYLO0: m_lo0     = masked(m_lo0, data, ENTRYLO_WMASK);
            ADDR_ENTRYLO1: m_lo1     = masked(m_lo1, data, ENTRYLO_WMASK);
            ADDR_CONTEXT:  m_context = masked(m_context, data, CONTEXT_WMASK);
            ADDR_ENTRYHI:  m_entryhi = masked(m_entryhi, data, ENTRYHI_WMASK);
            ADDR_STATUS:   m_status  = masked(m_status, data, STATUS_WMASK);
            ADDR_CAUSE:    m_cause   = masked(m_cause, data, CAUSE_WMASK);
            ADDR_EPC:      m_epc     = data;
            ADDR_EBASE:    m_ebase   = masked(m_ebase, data, EBASE_WMASK);
            ADDR_CONFIG:   m_config  = masked(m_config, data, CONFIG_WMASK);
            default: ;  // Count, Compare and read-only registers
        endcase
    endtask

    task automatic apply_tlbwi();
        logic [3:0] i;
        i         = m_index[3:0];
        t_vpn2[i] = m_entryhi[31:13];
        t_asid[i] = m_entryhi[7:0];
        t_g[i]    = m_lo0[0] & m_lo1[0];
        t_v[i]    = m_lo0[1] | m_lo1[1];
    endtask

    // Lowest valid entry matching VPN2 and, unless global, ASID
    function automatic logic [31:0] probe_lookup();
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (t_v[i] && t_vpn2[i] == m_entryhi[31:13]
                && (t_g[i] || t_asid[i] == m_entryhi[7:0]))
                return 32'(i);
        end
        return 32'h8000_0000;
    endfunction

    function automatic logic [31:0] vector_target(exc_req_t e);
        logic [31:0] base;
        base = m_status[22] ? VEC_BOOT_BASE : {m_ebase[31:12], 12'b0};
        if (e.refill && !m_status[1])
            return base + OFF_REFILL;
        if (e.code == EXC_INT && m_cause[23])
            return base + OFF_IRQ;
        return base + OFF_GENERAL;
    endfunction

    task automatic apply_exception(exc_req_t e);
        m_status[1]      = 1'b1;
        m_cause[31]      = e.bd;
        m_cause[6:2]     = e.code;
        m_context[22:4]  = e.bad_vaddr[31:13];
        m_entryhi[31:13] = e.bad_vaddr[31:13];
        if (e.asid_we)
            m_entryhi[7:0] = e.asid;
        m_epc = e.epc;
        if (e.badv_we)
            m_badv = e.bad_vaddr;
    endtask

    task automatic random_exception(output exc_req_t e);
        e.code      = 5'($random(seed) & 3);
        e.bd        = 1'($random(seed));
        e.refill    = 1'($random(seed));
        e.epc       = $random(seed) & 32'hFFFF_FFFC;
        e.bad_vaddr = $random(seed);
        e.badv_we   = 1'($random(seed));
        e.asid      = 8'($random(seed));
        e.asid_we   = 1'($random(seed));
    endtask

    // Few VPN2 and ASID values so probes hit often
    task automatic random_entryhi(output logic [31:0] v);
        v = {16'h0040, 3'($random(seed)), 11'b0, 2'($random(seed))};
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        rsp_ready_i = ($random(seed) & 3) != 0;  // Back-pressure about a quarter of the time
    endtask

    task automatic cpu_op(cp0_op_e op, cp0_addr_t addr, logic [31:0] wdata);
        cp0_rsp_t  exp;
        redirect_t eret_target;
        logic      done;
        int        n;
        exp.rdata          = (op == OP_MFC0) ? expected_read(addr) :
                             (op == OP_ERET) ? m_epc : '0;
        eret_target.target = m_epc;
        req_i.op    = op;
        req_i.addr  = addr;
        req_i.wdata = wdata;
        req_valid_i = 1'b1;
        dbg_addr_i  = addr;
        done = 1'b0;
        for (n = 0; n < TIMEOUT && !done; n++) begin
            @(negedge clk);
            check_bit("rsp_valid_o", rsp_valid_o, 1'b0);  // No stray response
            check_bit("redirect_valid_o", redirect_valid_o, 1'b0);  // Pulse is over
            done = req_ready_o;
            if (done && op == OP_MFC0)
                check_rsp("dbg_data_o", dbg_data_o, exp);
            next_cycle();
        end
        if (!done)
            fail_run("Timeout: request was never accepted");
        req_valid_i = 1'b0;
        case (op)
            OP_MTC0:  apply_mtc0(addr, wdata);
            OP_TLBWI: apply_tlbwi();
            OP_TLBP:  m_index = probe_lookup();
            OP_ERET:  m_status[1] = 1'b0;
            default: ;
        endcase
        done = 1'b0;
        for (n = 0; n < TIMEOUT && !done; n++) begin
            @(negedge clk);
            check_bit("rsp_valid_o", rsp_valid_o, 1'b1);  // Held until taken
            if (!rsp_ready_i)
                check_bit("req_ready_o", req_ready_o, 1'b0);  // Full register stalls
            if (n == 0) begin
                check_bit("redirect_valid_o", redirect_valid_o, op == OP_ERET);
                if (op == OP_ERET)
                    check_redirect(redirect_o, eret_target);
            end
            done = rsp_valid_o && rsp_ready_i;
            if (done) begin
                check_rsp("rsp_o", rsp_o, exp);
                check_bit("user_mode_o", user_mode_o, m_status[4:1] == 4'b1000);
                check_bit("asid_o", asid_o, m_entryhi[7:0]);
            end
            next_cycle();
        end
        if (!done)
            fail_run("Timeout: response was never taken");
    endtask

    task automatic take_exception(exc_req_t e);
        redirect_t exp;
        exp.target  = vector_target(e);
        exc_i       = e;
        exc_valid_i = 1'b1;
        req_i.op    = OP_MFC0;
        req_i.addr  = ADDR_STATUS;
        req_valid_i = 1'b1;
        @(negedge clk);
        check_bit("req_ready_o", req_ready_o, 1'b0);  // Exception wins
        next_cycle();
        exc_valid_i = 1'b0;
        req_valid_i = 1'b0;
        apply_exception(e);
        @(negedge clk);
        check_bit("redirect_valid_o", redirect_valid_o, 1'b1);
        check_redirect(redirect_o, exp);
        next_cycle();
    endtask

    task automatic wait_irq(logic exp);
        logic seen;
        int   n;
        seen = 1'b0;
        for (n = 0; n < TIMEOUT && !seen; n++) begin
            @(negedge clk);
            seen = irq_o === exp;
            next_cycle();
        end
        if (!seen)
            fail_run($sformatf("Timeout: irq_o did not go to %0d", exp));
    endtask

    initial begin
        exc_req_t    e;
        logic [31:0] data;
        int          k;
        int          j;
        rst_n       = 1'b0;
        req_i       = '0;
        req_valid_i = 1'b0;
        rsp_ready_i = 1'b0;
        exc_i       = '0;
        exc_valid_i = 1'b0;
        hw_int_i    = '0;
        dbg_addr_i  = '0;
        m_status  = STATUS_RESET;
        m_cause   = '0;
        m_context = '0;
        m_ebase   = EBASE_RESET;
        m_entryhi = '0;
        m_lo0     = '0;
        m_lo1     = '0;
        m_index   = '0;
        m_config  = '0;
        for (k = 0; k < TLB_ENTRIES; k++)
            t_v[k] = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
        check_bit("req_ready_o", req_ready_o, 1'b0);
        check_bit("redirect_valid_o", redirect_valid_o, 1'b0);
        check_bit("irq_o", irq_o, 1'b0);
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // First exception fills EPC and BadVAddr
        random_exception(e);
        e.badv_we = 1'b1;
        take_exception(e);
        cpu_op(OP_ERET, '0, '0);

        for (k = 0; k < 200; k++) begin
            if ($random(seed) & 1)
                cpu_op(OP_MTC0, reg_list[{$random(seed)} % 13], $random(seed));
            else
                cpu_op(OP_MFC0, reg_list[{$random(seed)} % 13], '0);
        end

        for (k = 0; k < 40; k++) begin
            if ($random(seed) & 1)
                cpu_op(OP_MTC0, ADDR_STATUS, $random(seed));
            if ($random(seed) & 1)
                cpu_op(OP_MTC0, ADDR_CAUSE, $random(seed));
            random_exception(e);
            take_exception(e);
            for (j = 0; j < 6; j++)
                cpu_op(OP_MFC0, exc_list[j], '0);
            if ($random(seed) & 1) begin
                cpu_op(OP_ERET, '0, '0);
                cpu_op(OP_MFC0, ADDR_STATUS, '0);
            end
        end

        for (k = 0; k < 48; k++) begin
            cpu_op(OP_MTC0, ADDR_INDEX, $random(seed));
            random_entryhi(data);
            cpu_op(OP_MTC0, ADDR_ENTRYHI, data);
            cpu_op(OP_MTC0, ADDR_ENTRYLO0, $random(seed));
            cpu_op(OP_MTC0, ADDR_ENTRYLO1, $random(seed));
            cpu_op(OP_TLBWI, '0, '0);
            random_entryhi(data);
            cpu_op(OP_MTC0, ADDR_ENTRYHI, data);
            cpu_op(OP_TLBP, '0, '0);
            cpu_op(OP_MFC0, ADDR_INDEX, '0);
        end

        cpu_op(OP_MTC0, ADDR_CAUSE, 32'h0);
        cpu_op(OP_MTC0, ADDR_STATUS, 32'h0000_FF01);  // IE, all lines unmasked
        @(negedge clk);
        @(negedge clk);
        check_bit("irq_o", irq_o, 1'b0);
        next_cycle();
        for (k = 0; k < 6; k++) begin
            hw_int_i = 6'b1 << k;
            wait_irq(1'b1);
            cpu_op(OP_MFC0, ADDR_CAUSE, '0);
            cpu_op(OP_MTC0, ADDR_STATUS, 32'h0000_FF01 & ~(32'h400 << k));
            wait_irq(1'b0);
            cpu_op(OP_MTC0, ADDR_STATUS, 32'h0000_FF01);
            wait_irq(1'b1);
            cpu_op(OP_MTC0, ADDR_STATUS, 32'h0000_FF03);  // EXL blocks it
            wait_irq(1'b0);
            cpu_op(OP_MTC0, ADDR_STATUS, 32'h0000_FF01);
            hw_int_i = '0;
            wait_irq(1'b0);
        end
        for (k = 0; k < 2; k++) begin
            cpu_op(OP_MTC0, ADDR_CAUSE, 32'h100 << k);
            wait_irq(1'b1);
            cpu_op(OP_MTC0, ADDR_CAUSE, 32'h0);
            wait_irq(1'b0);
        end

        cpu_op(OP_MTC0, ADDR_STATUS, 32'h0000_8001);  // Only IM7
        cpu_op(OP_MTC0, ADDR_COUNT, 32'h0000_0100);
        cpu_op(OP_MTC0, ADDR_COMPARE, 32'h0000_0140);
        wait_irq(1'b1);
        cpu_op(OP_MTC0, ADDR_COMPARE, 32'h0);
        wait_irq(1'b0);

        $display("No errors");
        $finish;
    end

endmodule

// ==== mips_cp0.f ====
hw/cp0_pkg.sv
hw/cp0_regs.sv
hw/cp0_irq.sv
hw/cp0_tlb.sv
hw/cp0_ctrl.sv
hw/cp0_top.sv
sim/cp0_tb.sv

// ==== Bender.yml ====
package:
  name: mips_cp0

sources:
  - hw/cp0_pkg.sv
  - hw/cp0_regs.sv
  - hw/cp0_irq.sv
  - hw/cp0_tlb.sv
  - hw/cp0_ctrl.sv
  - hw/cp0_top.sv
  - target: simulation
    files:
      - sim/cp0_tb.sv
